//--- proc.f
+incdir+src
src/procPkg.sv
src/fetch.sv
src/control.sv
src/decode.sv
src/execute.sv
src/memory.sv
src/proc.sv
tb/procTb.sv

//--- src/control.sv
// Main decoder: maps the opcode field to the control bundle
// Purely combinational, one instance feeds every stage

`timescale 1ns/100ps

`include "proc_cfg.svh"

module control (
   input  logic [`PROC_DW-1:0] instr,
   output procPkg::ctrlT       ctrl
);

   procPkg::opcodeT opcode;

   assign opcode = procPkg::opcodeT'(instr[15:11]);

   always_comb
   begin
      ctrl        = '0;
      ctrl.aluOp  = procPkg::ALU_ADD;
      ctrl.immSel = procPkg::IMM5S;
      case (opcode)
         procPkg::HALT:
            ctrl.halt = 1'b1;
         procPkg::NOP:
            ;
         procPkg::ADD:
            ctrl.regWrite = 1'b1;
         procPkg::SUB:
         begin
            ctrl.regWrite = 1'b1;
            ctrl.aluOp    = procPkg::ALU_SUB;
         end
         procPkg::AND:
         begin
            ctrl.regWrite = 1'b1;
            ctrl.aluOp    = procPkg::ALU_AND;
         end
         procPkg::XOR:
         begin
            ctrl.regWrite = 1'b1;
            ctrl.aluOp    = procPkg::ALU_XOR;
         end
         procPkg::ADDI:
         begin
            ctrl.regWrite = 1'b1;
            ctrl.writeRt  = 1'b1;
            ctrl.aluSrc   = 1'b1;
         end
         // Address is rs + imm5 for both memory ops
         procPkg::LD:
         begin
            ctrl.regWrite = 1'b1;
            ctrl.writeRt  = 1'b1;
            ctrl.aluSrc   = 1'b1;
            ctrl.memRead  = 1'b1;
         end
         procPkg::ST:
         begin
            ctrl.aluSrc   = 1'b1;
            ctrl.memWrite = 1'b1;
         end
         procPkg::LBI:
         begin
            ctrl.regWrite = 1'b1;
            ctrl.writeRs  = 1'b1;
            ctrl.aluSrc   = 1'b1;
            ctrl.aluOp    = procPkg::ALU_PASSB;
            ctrl.immSel   = procPkg::IMM8S;
         end
         procPkg::SLBI:
         begin
            ctrl.regWrite = 1'b1;
            ctrl.writeRs  = 1'b1;
            ctrl.aluSrc   = 1'b1;
            ctrl.aluOp    = procPkg::ALU_SHLOR;
            ctrl.immSel   = procPkg::IMM8Z;
         end
         procPkg::BEQZ:
         begin
            ctrl.branchZ = 1'b1;
            ctrl.immSel  = procPkg::IMM8S;
         end
         procPkg::BNEZ:
         begin
            ctrl.branchNz = 1'b1;
            ctrl.immSel   = procPkg::IMM8S;
         end
         procPkg::J:
         begin
            ctrl.jump   = 1'b1;
            ctrl.immSel = procPkg::IMM11S;
         end
         default:
         begin
            // Unknown opcode stops the machine
            ctrl.illegal = 1'b1;
            ctrl.halt    = 1'b1;
         end
      endcase
   end

endmodule

//--- src/decode.sv
// Decode stage: register file, immediate extension, destination select
// The write port commits at the clock edge closing the instruction

`timescale 1ns/100ps

`include "proc_cfg.svh"

module decode (
   input  logic                clk,
   input  logic                rst,
   input  logic [`PROC_DW-1:0] instr,
   input  procPkg::ctrlT       ctrl,
   input  logic                halted,
   input  logic [`PROC_DW-1:0] writeData,
   output logic [`PROC_DW-1:0] rsData,
   output logic [`PROC_DW-1:0] rtData,
   output logic [`PROC_DW-1:0] imm,
   output logic [`PROC_RA-1:0] destReg
);

   logic [`PROC_DW-1:0] regs [0:(1 << `PROC_RA) - 1];
   logic [`PROC_RA-1:0] rs;
   logic [`PROC_RA-1:0] rt;
   logic [`PROC_RA-1:0] rd;

   assign rs = instr[10:8];
   assign rt = instr[7:5];
   assign rd = instr[4:2];

   assign rsData = regs[rs];
   assign rtData = regs[rt];

   // LBI/SLBI write rs, I-type writes rt, R-type writes rd
   always_comb
   begin
      if (ctrl.writeRs)
         destReg = rs;
      else if (ctrl.writeRt)
         destReg = rt;
      else
         destReg = rd;
   end

   always_comb
   begin
      case (ctrl.immSel)
         procPkg::IMM5S:
            imm = {{(`PROC_DW - 5){instr[4]}}, instr[4:0]};
         procPkg::IMM8S:
            imm = {{(`PROC_DW - 8){instr[7]}}, instr[7:0]};
         procPkg::IMM8Z:
            imm = {{(`PROC_DW - 8){1'b0}}, instr[7:0]};
         default:
            imm = {{(`PROC_DW - 11){instr[10]}}, instr[10:0]};
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         for (int i = 0; i < (1 << `PROC_RA); i++)
            regs[i] <= '0;
      end
      else if (ctrl.regWrite && !halted)
      begin
         regs[destReg] <= writeData;
      end
   end

endmodule

//--- src/execute.sv
// Execute stage: ALU, memory address, branch test and next PC
// Branch and jump targets are relative to PC + 1 and wrap at imem size

`timescale 1ns/100ps

`include "proc_cfg.svh"

module execute (
   input  logic [`PROC_IAW-1:0] pc,
   input  logic [`PROC_DW-1:0]  rsData,
   input  logic [`PROC_DW-1:0]  rtData,
   input  logic [`PROC_DW-1:0]  imm,
   input  procPkg::ctrlT        ctrl,
   output logic [`PROC_DW-1:0]  aluOut,
   output logic [`PROC_IAW-1:0] nextPc
);

   logic [`PROC_DW-1:0]  opB;
   logic [`PROC_IAW-1:0] pcPlus1;
   logic [`PROC_IAW-1:0] target;
   logic                 rsZero;
   logic                 taken;

   assign opB = ctrl.aluSrc ? imm : rtData;

   always_comb
   begin
      case (ctrl.aluOp)
         procPkg::ALU_ADD:
            aluOut = rsData + opB;
         procPkg::ALU_SUB:
            aluOut = rsData - opB;
         procPkg::ALU_AND:
            aluOut = rsData & opB;
         procPkg::ALU_XOR:
            aluOut = rsData ^ opB;
         procPkg::ALU_PASSB:
            aluOut = opB;
         // SLBI: old rs moves up a byte, new byte goes in the bottom
         procPkg::ALU_SHLOR:
            aluOut = (rsData << 8) | opB;
         default:
            aluOut = '0;
      endcase
   end

   assign pcPlus1 = pc + 1'b1;

   // Truncation of imm gives the modulo wrap
   assign target = pcPlus1 + imm[`PROC_IAW-1:0];

   assign rsZero = (rsData == '0);

   always_comb
   begin
      taken = ctrl.jump;
      if (ctrl.branchZ && rsZero)
         taken = 1'b1;
      if (ctrl.branchNz && !rsZero)
         taken = 1'b1;
   end

   assign nextPc = taken ? target : pcPlus1;

endmodule

//--- src/fetch.sv
// Fetch stage: program counter, loadable instruction memory and halt state
// The memory is written through the load port only while rst is high

`timescale 1ns/100ps

`include "proc_cfg.svh"

module fetch (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 imemLoad,
   input  logic [`PROC_IAW-1:0] imemAddr,
   input  logic [`PROC_DW-1:0]  imemData,
   input  logic [`PROC_IAW-1:0] nextPc,
   input  logic                 haltReq,
   input  logic                 illegalReq,
   output logic [`PROC_IAW-1:0] pc,
   output logic [`PROC_DW-1:0]  instr,
   output logic                 halted,
   output logic                 illegalSeen
);

   logic [`PROC_DW-1:0] imem [0:(1 << `PROC_IAW) - 1];

   // Program load port
   always_ff @(posedge clk)
   begin
      if (rst && imemLoad)
         imem[imemAddr] <= imemData;
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         pc          <= '0;
         halted      <= 1'b0;
         illegalSeen <= 1'b0;
      end
      else if (!halted)
      begin
         // PC stays on the halting instruction
         if (haltReq)
            halted <= 1'b1;
         else
            pc <= nextPc;
         if (illegalReq)
            illegalSeen <= 1'b1;
      end
   end

   // Memory contents are still being loaded during reset, so issue NOP
   // then and after halt
   always_comb
   begin
      if (rst || halted)
         instr = {procPkg::NOP, {(`PROC_DW - 5){1'b0}}};
      else
         instr = imem[pc];
   end

endmodule

//--- src/memory.sv
// Memory stage: word-addressed data memory and writeback select
// Stores commit at the clock edge, loads read combinationally

`timescale 1ns/100ps

`include "proc_cfg.svh"

module memory (
   input  logic                clk,
   input  logic                rst,
   input  procPkg::ctrlT       ctrl,
   input  logic                halted,
   input  logic [`PROC_DW-1:0] aluOut,
   input  logic [`PROC_DW-1:0] rtData,
   output logic [`PROC_DW-1:0] writeData
);

   logic [`PROC_DW-1:0]  dmem [0:(1 << `PROC_DAW) - 1];
   logic [`PROC_DAW-1:0] addr;

   // Upper address bits ignored
   assign addr = aluOut[`PROC_DAW-1:0];

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         for (int i = 0; i < (1 << `PROC_DAW); i++)
            dmem[i] <= '0;
      end
      else if (ctrl.memWrite && !halted)
      begin
         dmem[addr] <= rtData;
      end
   end

   // Loaded word for LD, ALU result for everything else
   assign writeData = ctrl.memRead ? dmem[addr] : aluOut;

endmodule

//--- src/proc.sv
// Top level of the single-cycle processor
// Load the program through the imem port while rst is high, then release
// rst and watch wbTrace, halted and err

`timescale 1ns/100ps

`include "proc_cfg.svh"

module proc (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 imemLoad,
   input  logic [`PROC_IAW-1:0] imemAddr,
   input  logic [`PROC_DW-1:0]  imemData,
   output logic [`PROC_IAW-1:0] pc,
   output procPkg::wbTraceT     wbTrace,
   output logic                 halted,
   output logic                 err
);

   procPkg::ctrlT        ctrl;
   logic [`PROC_DW-1:0]  instr;
   logic [`PROC_IAW-1:0] nextPc;
   logic [`PROC_DW-1:0]  rsData;
   logic [`PROC_DW-1:0]  rtData;
   logic [`PROC_DW-1:0]  imm;
   logic [`PROC_RA-1:0]  destReg;
   logic [`PROC_DW-1:0]  aluOut;
   logic [`PROC_DW-1:0]  writeData;

   fetch fetchStage (
      .clk         (clk),
      .rst         (rst),
      .imemLoad    (imemLoad),
      .imemAddr    (imemAddr),
      .imemData    (imemData),
      .nextPc      (nextPc),
      .haltReq     (ctrl.halt),
      .illegalReq  (ctrl.illegal),
      .pc          (pc),
      .instr       (instr),
      .halted      (halted),
      .illegalSeen (err)
   );

   control ctrlUnit (
      .instr (instr),
      .ctrl  (ctrl)
   );

   decode decodeStage (
      .clk       (clk),
      .rst       (rst),
      .instr     (instr),
      .ctrl      (ctrl),
      .halted    (halted),
      .writeData (writeData),
      .rsData    (rsData),
      .rtData    (rtData),
      .imm       (imm),
      .destReg   (destReg)
   );

   execute executeStage (
      .pc     (pc),
      .rsData (rsData),
      .rtData (rtData),
      .imm    (imm),
      .ctrl   (ctrl),
      .aluOut (aluOut),
      .nextPc (nextPc)
   );

   memory memoryStage (
      .clk       (clk),
      .rst       (rst),
      .ctrl      (ctrl),
      .halted    (halted),
      .aluOut    (aluOut),
      .rtData    (rtData),
      .writeData (writeData)
   );

   // Register write committing at the end of this cycle
   assign wbTrace.valid  = ctrl.regWrite & ~halted;
   assign wbTrace.regIdx = destReg;
   assign wbTrace.data   = writeData;

endmodule

//--- src/procPkg.sv
// Shared types for the single-cycle processor
// Opcodes, ALU operations, immediate formats, control bundle and
// the writeback trace seen by the testbench

`include "proc_cfg.svh"

package procPkg;

   // Opcode field, instr[15:11]
   typedef enum logic [4:0] {
      HALT = 5'd0,
      NOP  = 5'd1,
      ADD  = 5'd4,
      SUB  = 5'd5,
      AND  = 5'd6,
      XOR  = 5'd7,
      ADDI = 5'd8,
      LD   = 5'd9,
      ST   = 5'd10,
      LBI  = 5'd12,
      SLBI = 5'd13,
      BEQZ = 5'd16,
      BNEZ = 5'd17,
      J    = 5'd20
   } opcodeT;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_XOR,
      ALU_PASSB,
      ALU_SHLOR
   } aluOpT;

   // How the immediate is pulled out of the instruction
   typedef enum logic [1:0] {
      IMM5S,
      IMM8S,
      IMM8Z,
      IMM11S
   } immSelT;

   typedef struct packed {
      logic   regWrite;
      logic   writeRt;   // rt is destination instead of rd
      logic   writeRs;   // rs is destination, LBI and SLBI
      logic   aluSrc;    // immediate as B operand
      aluOpT  aluOp;
      immSelT immSel;
      logic   memRead;
      logic   memWrite;
      logic   branchZ;
      logic   branchNz;
      logic   jump;
      logic   halt;
      logic   illegal;
   } ctrlT;

   // One register write committing this cycle
   typedef struct packed {
      logic                valid;
      logic [`PROC_RA-1:0] regIdx;
      logic [`PROC_DW-1:0] data;
   } wbTraceT;

endpackage

//--- src/proc_cfg.svh
// Sizing macros for the single-cycle 16-bit processor
// Include in any file that needs datapath, register or memory widths

`ifndef PROC_CFG_SVH
`define PROC_CFG_SVH

// Data and instruction width
`define PROC_DW 16

// Register address width, eight registers
`define PROC_RA 3

// Instruction memory address width, word addressed
`define PROC_IAW 8

// Data memory address width, word addressed
`define PROC_DAW 8

`endif

//--- tb/procTb.sv
// Testbench for the single-cycle processor
// Each test loads a small program during reset, runs it to halt and
// compares every committed register write with a table of expected values

`timescale 1ns/100ps

`include "proc_cfg.svh"

module procTb;

   logic                 clk;
   logic                 rst;
   logic                 imemLoad;
   logic [`PROC_IAW-1:0] imemAddr;
   logic [`PROC_DW-1:0]  imemData;
   logic [`PROC_IAW-1:0] pc;
   procPkg::wbTraceT     wbTrace;
   logic                 halted;
   logic                 err;

   // Programs and expected writebacks of all tests back to back
   logic [`PROC_DW-1:0] progQ [$];
   logic [`PROC_RA-1:0] expRegQ [$];
   logic [`PROC_DW-1:0] expDataQ [$];
   int                  progBound [$];
   int                  expBound [$];
   bit                  errQ [$];

   int cycles;
   int cycleLimit;

   proc dut (
      .clk      (clk),
      .rst      (rst),
      .imemLoad (imemLoad),
      .imemAddr (imemAddr),
      .imemData (imemData),
      .pc       (pc),
      .wbTrace  (wbTrace),
      .halted   (halted),
      .err      (err)
   );

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   always @(posedge clk)
   begin
      cycles = cycles + 1;
      if (cycleLimit > 0 && cycles >= cycleLimit)
      begin
         $display("Timeout: run did not finish within %0d cycles", cycleLimit);
         $display("tests failed");
         $fatal(1, "timeout");
      end
   end

   function automatic logic [15:0] encodeR(procPkg::opcodeT op, logic [2:0] rs,
                                           logic [2:0] rt, logic [2:0] rd);
      return {op, rs, rt, rd, 2'b00};
   endfunction

   function automatic logic [15:0] encodeI(procPkg::opcodeT op, logic [2:0] rs,
                                           logic [2:0] rt, logic [4:0] imm5);
      return {op, rs, rt, imm5};
   endfunction

   function automatic logic [15:0] encodeB(procPkg::opcodeT op, logic [2:0] rs,
                                           logic [7:0] imm8);
      return {op, rs, imm8};
   endfunction

   function automatic logic [15:0] encodeJ(logic [10:0] off);
      return {procPkg::J, off};
   endfunction

   task automatic checkValue(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
      if (got !== exp)
      begin
         $display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
         $display("tests failed");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic reportError(input string msg);
      $display("%s at %0t", msg, $time);
      $display("tests failed");
      $fatal(1, msg);
   endtask

   task automatic startTest(input bit expectErr);
      progBound.push_back(progQ.size());
      expBound.push_back(expDataQ.size());
      errQ.push_back(expectErr);
   endtask

   task automatic addInstr(input logic [15:0] word);
      progQ.push_back(word);
   endtask

   task automatic expectWrite(input logic [2:0] regIdx, input logic [15:0] data);
      expRegQ.push_back(regIdx);
      expDataQ.push_back(data);
   endtask

   task automatic buildTables();
      // Register ALU operations
      startTest(1'b0);
      addInstr(encodeB(procPkg::LBI, 3'd1, 8'd25));
      expectWrite(3'd1, 16'h0019);
      addInstr(encodeB(procPkg::LBI, 3'd2, 8'd7));
      expectWrite(3'd2, 16'h0007);
      addInstr(encodeR(procPkg::ADD, 3'd1, 3'd2, 3'd3));
      expectWrite(3'd3, 16'h0020);
      addInstr(encodeR(procPkg::SUB, 3'd1, 3'd2, 3'd4));
      expectWrite(3'd4, 16'h0012);
      addInstr(encodeR(procPkg::AND, 3'd1, 3'd2, 3'd5));
      expectWrite(3'd5, 16'h0001);
      addInstr(encodeR(procPkg::XOR, 3'd1, 3'd2, 3'd6));
      expectWrite(3'd6, 16'h001E);
      // imm5 of -3
      addInstr(encodeI(procPkg::ADDI, 3'd1, 3'd7, 5'h1D));
      expectWrite(3'd7, 16'h0016);
      addInstr(16'h0000);

      // Constant building
      startTest(1'b0);
      addInstr(encodeB(procPkg::LBI, 3'd1, 8'h9C));
      expectWrite(3'd1, 16'hFF9C);
      addInstr(encodeB(procPkg::SLBI, 3'd1, 8'h35));
      expectWrite(3'd1, 16'h9C35);
      addInstr(16'h0000);

      // Memory roundtrip where stores leave no trace
      startTest(1'b0);
      addInstr(encodeB(procPkg::LBI, 3'd2, 8'h5A));
      expectWrite(3'd2, 16'h005A);
      addInstr(encodeB(procPkg::SLBI, 3'd2, 8'h3C));
      expectWrite(3'd2, 16'h5A3C);
      addInstr(encodeB(procPkg::LBI, 3'd3, 8'hA5));
      expectWrite(3'd3, 16'hFFA5);
      addInstr(encodeB(procPkg::LBI, 3'd4, 8'h04));
      expectWrite(3'd4, 16'h0004);
      addInstr(encodeI(procPkg::ST, 3'd4, 3'd2, 5'd3));
      addInstr(encodeI(procPkg::ST, 3'd4, 3'd3, 5'h1E));
      addInstr(encodeI(procPkg::LD, 3'd4, 3'd5, 5'd3));
      expectWrite(3'd5, 16'h5A3C);
      addInstr(encodeI(procPkg::LD, 3'd4, 3'd6, 5'h1E));
      expectWrite(3'd6, 16'hFFA5);
      addInstr(16'h0000);

      // Control flow must skip the LBI of 0xEE at 2 and 6
      startTest(1'b0);
      addInstr(encodeB(procPkg::LBI, 3'd1, 8'h00));
      expectWrite(3'd1, 16'h0000);
      addInstr(encodeB(procPkg::BEQZ, 3'd1, 8'd1));
      addInstr(encodeB(procPkg::LBI, 3'd2, 8'hEE));
      addInstr(encodeB(procPkg::BNEZ, 3'd1, 8'd1));
      addInstr(encodeB(procPkg::LBI, 3'd3, 8'h21));
      expectWrite(3'd3, 16'h0021);
      addInstr(encodeJ(11'd1));
      addInstr(encodeB(procPkg::LBI, 3'd4, 8'hEE));
      addInstr(encodeB(procPkg::LBI, 3'd5, 8'h42));
      expectWrite(3'd5, 16'h0042);
      addInstr(16'h0000);

      // Illegal opcode 31 after one ADDI
      startTest(1'b1);
      addInstr(encodeI(procPkg::ADDI, 3'd0, 3'd1, 5'd5));
      expectWrite(3'd1, 16'h0005);
      addInstr({5'd31, 11'd0});

      // Registers written before the last reset must read as zero
      startTest(1'b0);
      addInstr(encodeR(procPkg::ADD, 3'd0, 3'd1, 3'd2));
      expectWrite(3'd2, 16'h0000);
      addInstr(encodeR(procPkg::ADD, 3'd0, 3'd6, 3'd3));
      expectWrite(3'd3, 16'h0000);
      addInstr(16'h0000);

      progBound.push_back(progQ.size());
      expBound.push_back(expDataQ.size());
   endtask

   // Entered and left just after a rising edge
   task automatic runTest(input int t);
      int                   pStart;
      int                   pLen;
      int                   eStart;
      int                   eCount;
      int                   seen;
      int                   c;
      int                   lastAddr;
      logic [`PROC_IAW-1:0] haltPc;

      pStart = progBound[t];
      pLen   = progBound[t + 1] - pStart;
      eStart = expBound[t];
      eCount = expBound[t + 1] - eStart;
      seen   = 0;

      rst = 1'b1;
      for (c = 0; c < 10 || c < pLen; c++)
      begin
         if (c < pLen)
         begin
            imemLoad = 1'b1;
            imemAddr = c[`PROC_IAW-1:0];
            imemData = progQ[pStart + c];
         end
         else
            imemLoad = 1'b0;
         @(posedge clk);
         #1;
      end
      imemLoad = 1'b0;
      rst      = 1'b0;

      // Trace is sampled mid-cycle
      forever
      begin
         @(negedge clk);
         if (halted)
            break;
         if (wbTrace.valid)
         begin
            if (seen >= eCount)
               reportError("More register writebacks than expected before halt");
            checkValue("wbTrace.regIdx", wbTrace.regIdx, expRegQ[eStart + seen]);
            checkValue("wbTrace.data", wbTrace.data, expDataQ[eStart + seen]);
            seen++;
         end
      end
      if (seen != eCount)
         reportError("Fewer register writebacks than expected before halt");
      checkValue("err", err, errQ[t]);

      // Every program stops on its last word
      lastAddr = pLen - 1;
      haltPc   = lastAddr[`PROC_IAW-1:0];

      // Machine must stay frozen
      repeat (20)
      begin
         @(negedge clk);
         checkValue("wbTrace.valid", wbTrace.valid, 1'b0);
         checkValue("pc", pc, haltPc);
         checkValue("halted", halted, 1'b1);
         checkValue("err", err, errQ[t]);
      end
      @(posedge clk);
      #1;
   endtask

   initial
   begin
      int t;
      int pLen;
      int eCount;

      rst        = 1'b1;
      imemLoad   = 1'b0;
      imemAddr   = '0;
      imemData   = '0;
      cycles     = 0;
      cycleLimit = 0;

      buildTables();

      // Reset, load, trace and halt hold per test plus slack
      for (t = 0; t < errQ.size(); t++)
      begin
         pLen       = progBound[t + 1] - progBound[t];
         eCount     = expBound[t + 1] - expBound[t];
         cycleLimit = cycleLimit + 10 + pLen + 4 * eCount + 20;
      end
      cycleLimit = cycleLimit + 50;

      @(posedge clk);
      #1;
      for (t = 0; t < errQ.size(); t++)
         runTest(t);

      $display("all tests passed");
      $finish;
   end

endmodule
